// ==== sample_capture_settings.svh ====
`ifndef SAMPLE_CAPTURE_SETTINGS_SVH
`define SAMPLE_CAPTURE_SETTINGS_SVH

// Lane and buffer geometry.
`define SC_LANES        4
`define SC_SAMPLE_W     16
`define SC_DEPTH_LOG2   6   // 64 samples per lane.

// Register bus word address layout.
`define SC_REG_ADDR_W   9
`define SC_WIN_BIT      8   // Set for the buffer window.
`define SC_LANE_LSB     6
`define SC_LANE_SEL_W   2

// Register word addresses.
`define SC_ADDR_CTRL    0
`define SC_ADDR_START   1
`define SC_ADDR_END     2
`define SC_ADDR_STATUS  3
`define SC_ADDR_LANE_EN 4

// CTRL and STATUS bit positions.
`define SC_CTRL_START     0
`define SC_CTRL_ONE_SHOT  1
`define SC_CTRL_WAIT_TRIG 2
`define SC_CTRL_STOP      3
`define SC_STATUS_ARMED   8

`endif

// ==== sample_capture_pkg.sv ====
`include "sample_capture_settings.svh"

package sample_capture_pkg;

  // ***********************************************************
  // Register bus
  // ***********************************************************

  // Request from the host side. Strobes are single cycle.
  typedef struct packed {
    logic                      wr;
    logic                      rd;
    logic [`SC_REG_ADDR_W-1:0] addr;
    logic [31:0]               wdata;
  } reg_req_t;

  // Read response, two cycles after rd.
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // ***********************************************************
  // Lane side
  // ***********************************************************

  // Broadcast to every lane.
  typedef struct packed {
    logic [`SC_DEPTH_LOG2-1:0] start_offset;
    logic [`SC_DEPTH_LOG2-1:0] end_offset;
    logic                      one_shot;   // Stop after end_offset.
    logic                      active;     // Value taken on cfg_update.
  } lane_cfg_t;

  // One sample per lane.
  typedef logic [`SC_LANES-1:0][`SC_SAMPLE_W-1:0] lane_samples_t;

endpackage

// ==== capture_csr.sv ====
`timescale 1ns/100ps
`include "sample_capture_settings.svh"

module capture_csr import sample_capture_pkg::*; (
  input  logic                 stream_in,
  input  logic                 arst_n,
  input  reg_req_t             reg_req,
  input  logic                 trigger,
  input  logic [`SC_LANES-1:0] lane_busy,
  output lane_cfg_t            lane_cfg,
  output logic                 cfg_update,
  output logic [`SC_LANES-1:0] lane_en,
  output logic [31:0]          csr_rdata
);

  logic [`SC_DEPTH_LOG2-1:0] start_q;
  logic [`SC_DEPTH_LOG2-1:0] end_q;
  logic [`SC_LANES-1:0]      lane_en_q;
  logic                      one_shot_q;
  logic                      active_q;
  logic                      armed_q;
  logic                      update_q;
  logic                      wr_ctrl;
  logic                      start_req;
  logic                      stop_req;
  logic                      trig_fire;
  logic [31:0]               rd_mux;

  // ***********************************************************
  // Write decode
  // ***********************************************************

  assign wr_ctrl   = reg_req.wr && (reg_req.addr == `SC_ADDR_CTRL);
  assign start_req = wr_ctrl && reg_req.wdata[`SC_CTRL_START];
  assign stop_req  = wr_ctrl && reg_req.wdata[`SC_CTRL_STOP];
  assign trig_fire = armed_q && trigger;

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      start_q   <= '0;
      end_q     <= '1;
      lane_en_q <= '1;  // All lanes on by default.
    end else if (reg_req.wr) begin
      case (reg_req.addr)
        `SC_ADDR_START:   start_q   <= reg_req.wdata[`SC_DEPTH_LOG2-1:0];
        `SC_ADDR_END:     end_q     <= reg_req.wdata[`SC_DEPTH_LOG2-1:0];
        `SC_ADDR_LANE_EN: lane_en_q <= reg_req.wdata[`SC_LANES-1:0];
        default: ;
      endcase
    end
  end

  // ***********************************************************
  // Start, stop and trigger sequencing
  // ***********************************************************

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      one_shot_q <= 1'b0;
      active_q   <= 1'b0;
      armed_q    <= 1'b0;
      update_q   <= 1'b0;
    end else begin
      update_q <= 1'b0;
      if (stop_req) begin  // Stop wins over start.
        active_q <= 1'b0;
        armed_q  <= 1'b0;
        update_q <= 1'b1;
      end else if (start_req) begin
        one_shot_q <= reg_req.wdata[`SC_CTRL_ONE_SHOT];
        armed_q    <= reg_req.wdata[`SC_CTRL_WAIT_TRIG];
        if (!reg_req.wdata[`SC_CTRL_WAIT_TRIG]) begin
          active_q <= 1'b1;
          update_q <= 1'b1;
        end
      end else if (trig_fire) begin
        armed_q  <= 1'b0;
        active_q <= 1'b1;
        update_q <= 1'b1;
      end
    end
  end

  assign cfg_update            = update_q;
  assign lane_en               = lane_en_q;
  assign lane_cfg.start_offset = start_q;
  assign lane_cfg.end_offset   = end_q;
  assign lane_cfg.one_shot     = one_shot_q;
  assign lane_cfg.active       = active_q;

  // ***********************************************************
  // Register read
  // ***********************************************************

  always_comb begin
    rd_mux = '0;  // Unmapped reads give zero.
    case (reg_req.addr)
      `SC_ADDR_CTRL:    rd_mux[`SC_CTRL_ONE_SHOT] = one_shot_q;
      `SC_ADDR_START:   rd_mux[`SC_DEPTH_LOG2-1:0] = start_q;
      `SC_ADDR_END:     rd_mux[`SC_DEPTH_LOG2-1:0] = end_q;
      `SC_ADDR_LANE_EN: rd_mux[`SC_LANES-1:0] = lane_en_q;
      `SC_ADDR_STATUS: begin
        rd_mux[`SC_LANES-1:0]    = lane_busy;
        rd_mux[`SC_STATUS_ARMED] = armed_q;
      end
      default: ;
    endcase
  end

  always_ff @(posedge stream_in) begin
    if (reg_req.rd) csr_rdata <= rd_mux;
  end

  // Software must not start on an empty region.
  a_region_order: assert property (@(posedge stream_in) disable iff (!arst_n)
    cfg_update && lane_cfg.active |-> lane_cfg.start_offset <= lane_cfg.end_offset);

endmodule

// ==== capture_lane.sv ====
`timescale 1ns/100ps
`include "sample_capture_settings.svh"

module capture_lane import sample_capture_pkg::*; (
  input  logic                      stream_in,
  input  logic                      arst_n,
  input  lane_cfg_t                 lane_cfg,
  input  logic                      cfg_update,
  input  logic                      lane_sel,
  input  logic                      sample_valid,
  input  logic [`SC_SAMPLE_W-1:0]   sample,
  input  logic [`SC_DEPTH_LOG2-1:0] rd_addr,
  output logic                      busy,
  output logic [`SC_SAMPLE_W-1:0]   rd_data
);

  localparam int unsigned DEPTH = 1 << `SC_DEPTH_LOG2;

  logic [`SC_SAMPLE_W-1:0]   mem [DEPTH];
  logic [`SC_DEPTH_LOG2-1:0] wr_addr;
  logic                      enable_q;
  logic                      wr_en;
  logic                      at_end;

  // ***********************************************************
  // Write engine
  // ***********************************************************

  assign wr_en  = enable_q && sample_valid;  // Idle lanes drop samples.
  assign at_end = wr_addr >= lane_cfg.end_offset;
  assign busy   = enable_q;

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      enable_q <= 1'b0;
    end else if (cfg_update) begin
      enable_q <= lane_cfg.active && lane_sel;
    end else if (wr_en && at_end && lane_cfg.one_shot) begin
      // Last word of a one-shot region.
      enable_q <= 1'b0;
    end
  end

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      wr_addr <= '0;
    end else if (cfg_update && lane_cfg.active) begin
      wr_addr <= lane_cfg.start_offset;
    end else if (wr_en) begin
      wr_addr <= at_end ? lane_cfg.start_offset : wr_addr + 1'b1;
    end
  end

  // ***********************************************************
  // Sample RAM
  // ***********************************************************

  always_ff @(posedge stream_in) begin
    if (wr_en) mem[wr_addr] <= sample;
  end

  // Read port, one cycle.
  always_ff @(posedge stream_in) begin
    rd_data <= mem[rd_addr];
  end

  // Holds as long as END is not moved below the pointer mid capture.
  a_addr_in_region: assert property (@(posedge stream_in) disable iff (!arst_n)
    busy && !cfg_update |-> wr_addr <= lane_cfg.end_offset);

endmodule

// ==== capture_readback.sv ====
`timescale 1ns/100ps
`include "sample_capture_settings.svh"

module capture_readback import sample_capture_pkg::*; (
  input  logic                      stream_in,
  input  logic                      arst_n,
  input  reg_req_t                  reg_req,
  input  lane_samples_t             lane_rd_data,
  input  logic [31:0]               csr_rdata,
  output logic [`SC_DEPTH_LOG2-1:0] rd_addr,
  output reg_rsp_t                  reg_rsp
);

  logic                      s1_valid;
  logic                      s1_win;
  logic [`SC_LANE_SEL_W-1:0] s1_lane;

  // Lane RAMs see the offset in the request cycle.
  assign rd_addr = reg_req.addr[`SC_DEPTH_LOG2-1:0];

  // ***********************************************************
  // Stage 1 while the RAM and csr registers read
  // ***********************************************************

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= reg_req.rd;
    end
  end

  always_ff @(posedge stream_in) begin
    s1_win  <= reg_req.addr[`SC_WIN_BIT];
    s1_lane <= reg_req.addr[`SC_LANE_LSB +: `SC_LANE_SEL_W];
  end

  // ***********************************************************
  // Stage 2 response register
  // ***********************************************************

  always_ff @(posedge stream_in or negedge arst_n) begin
    if (!arst_n) begin
      reg_rsp <= '0;
    end else begin
      reg_rsp.valid <= s1_valid;
      if (s1_valid) begin
        reg_rsp.rdata <= s1_win ? 32'(lane_rd_data[s1_lane]) : csr_rdata;
      end
    end
  end

  // Fixed two cycle read latency.
  a_rsp_latency: assert property (@(posedge stream_in) disable iff (!arst_n)
    reg_req.rd |-> ##2 reg_rsp.valid);

endmodule

// ==== sample_capture_top.sv ====
`timescale 1ns/100ps
`include "sample_capture_settings.svh"

module sample_capture_top import sample_capture_pkg::*; (
  input  logic                 stream_in,
  input  logic                 arst_n,
  input  logic                 sample_valid,
  input  lane_samples_t        sample_data,
  input  logic                 trigger,
  input  reg_req_t             reg_req,
  output reg_rsp_t             reg_rsp,
  output logic [`SC_LANES-1:0] lane_busy
);

  lane_cfg_t                 lane_cfg;
  logic                      cfg_update;
  logic [`SC_LANES-1:0]      lane_en;
  logic [31:0]               csr_rdata;
  logic [`SC_DEPTH_LOG2-1:0] rd_addr;
  lane_samples_t             lane_rd_data;

  capture_csr csr_i (
    .stream_in  (stream_in),
    .arst_n     (arst_n),
    .reg_req    (reg_req),
    .trigger    (trigger),
    .lane_busy  (lane_busy),
    .lane_cfg   (lane_cfg),
    .cfg_update (cfg_update),
    .lane_en    (lane_en),
    .csr_rdata  (csr_rdata)
  );

  // One write engine and RAM per lane.
  for (genvar i = 0; i < `SC_LANES; i++) begin : g_lane
    capture_lane lane_i (
      .stream_in    (stream_in),
      .arst_n       (arst_n),
      .lane_cfg     (lane_cfg),
      .cfg_update   (cfg_update),
      .lane_sel     (lane_en[i]),
      .sample_valid (sample_valid),
      .sample       (sample_data[i]),
      .rd_addr      (rd_addr),
      .busy         (lane_busy[i]),
      .rd_data      (lane_rd_data[i])
    );
  end

  capture_readback readback_i (
    .stream_in    (stream_in),
    .arst_n       (arst_n),
    .reg_req      (reg_req),
    .lane_rd_data (lane_rd_data),
    .csr_rdata    (csr_rdata),
    .rd_addr      (rd_addr),
    .reg_rsp      (reg_rsp)
  );

endmodule

// ==== tb_sample_capture.sv ====
`timescale 1ns/100ps
`include "sample_capture_settings.svh"

module tb_sample_capture import sample_capture_pkg::*; ();

  localparam int LANES = `SC_LANES;
  localparam int DEPTH = 1 << `SC_DEPTH_LOG2;
  localparam int SW    = `SC_SAMPLE_W;

  logic             stream_in;
  logic             arst_n;
  logic             sample_valid;
  lane_samples_t    sample_data;
  logic             trigger;
  reg_req_t         reg_req;
  reg_rsp_t         reg_rsp;
  logic [LANES-1:0] lane_busy;

  byte         cmd_q[$];   // Pattern file rows.
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  string       name_q[$];
  int unsigned budget_cycles = 0;

  int unsigned exp_due[$];   // Reads in flight.
  logic [31:0] exp_data[$];
  string       exp_name[$];
  int unsigned cyc = 0;
  int unsigned error_count = 0;
  logic [31:0] lfsr;

  // Reference model of the lanes.
  logic [SW-1:0]             m_mem [LANES][DEPTH];
  logic [`SC_DEPTH_LOG2-1:0] m_addr [LANES];
  logic [LANES-1:0]          m_en;
  logic [LANES-1:0]          m_lane_en;
  logic [`SC_DEPTH_LOG2-1:0] m_start;
  logic [`SC_DEPTH_LOG2-1:0] m_end;
  logic                      m_one_shot;
  logic                      m_armed;

  sample_capture_top dut_i (
    .stream_in    (stream_in),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .trigger      (trigger),
    .reg_req      (reg_req),
    .reg_rsp      (reg_rsp),
    .lane_busy    (lane_busy)
  );

  initial stream_in = 1'b0;
  always #2 stream_in = ~stream_in;

  // ***********************************************************
  // Helpers
  // ***********************************************************

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "Stopped at first mismatch.");
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_sample(output logic [SW-1:0] word);
    for (int b = 0; b < SW; b++) begin
      word[b] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int unsigned budget;
    string       line;
    string       cmd;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    fd = $fopen("sample_capture_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sample_capture_patterns.txt.");
      $display("Simulation FAILED");
      $fatal(1, "Missing pattern file.");
    end else begin
      budget = 200;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#" &&
            $sscanf(line, "%s %h %h %s", cmd, addr, data, name) == 4) begin
          cmd_q.push_back(cmd.getc(0));
          addr_q.push_back(addr);
          data_q.push_back(data);
          name_q.push_back(name);
          budget += 8;
          if (cmd == "S") budget += data;  // One cycle per sample.
        end
      end
      $fclose(fd);
      budget_cycles = budget;
    end
  endtask

  task automatic model_reset();
    for (int l = 0; l < LANES; l++) begin
      m_addr[l] = '0;
      for (int d = 0; d < DEPTH; d++) m_mem[l][d] = 'x;
    end
    m_en       = '0;
    m_lane_en  = '1;
    m_start    = '0;
    m_end      = '1;
    m_one_shot = 1'b0;
    m_armed    = 1'b0;
  endtask

  task automatic model_start();
    for (int l = 0; l < LANES; l++) begin
      m_en[l]   = m_lane_en[l];
      m_addr[l] = m_start;
    end
  endtask

  task automatic model_sample(input lane_samples_t s);
    logic at_end;
    for (int l = 0; l < LANES; l++) begin
      if (m_en[l]) begin
        m_mem[l][m_addr[l]] = s[l];
        at_end = m_addr[l] >= m_end;
        if (at_end && m_one_shot) m_en[l] = 1'b0;
        m_addr[l] = at_end ? m_start : m_addr[l] + 1'b1;  // Wrap rule.
      end
    end
  endtask

  // ***********************************************************
  // Bus and stream drivers
  // ***********************************************************

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    reg_req_t req;
    req       = '0;
    req.wr    = 1'b1;
    req.addr  = addr[`SC_REG_ADDR_W-1:0];
    req.wdata = data;
    @(posedge stream_in);
    reg_req <= req;
    @(posedge stream_in);
    reg_req <= '0;
    @(posedge stream_in);
    case (addr)
      `SC_ADDR_START:   m_start   = data[`SC_DEPTH_LOG2-1:0];
      `SC_ADDR_END:     m_end     = data[`SC_DEPTH_LOG2-1:0];
      `SC_ADDR_LANE_EN: m_lane_en = data[LANES-1:0];
      `SC_ADDR_CTRL: begin
        if (data[`SC_CTRL_STOP]) begin
          m_en    = '0;
          m_armed = 1'b0;
        end else if (data[`SC_CTRL_START]) begin
          m_one_shot = data[`SC_CTRL_ONE_SHOT];
          m_armed    = data[`SC_CTRL_WAIT_TRIG];
          if (!data[`SC_CTRL_WAIT_TRIG]) model_start();
        end
      end
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [31:0] addr, input logic [31:0] data,
                          input string name);
    reg_req_t    req;
    logic [31:0] expected;
    int          lane;
    int          off;
    expected = data;  // Register reads come from the file.
    if (addr[`SC_WIN_BIT]) begin
      lane     = addr[`SC_LANE_LSB +: `SC_LANE_SEL_W];
      off      = addr[`SC_DEPTH_LOG2-1:0];
      expected = 32'(m_mem[lane][off]);
    end
    req      = '0;
    req.rd   = 1'b1;
    req.addr = addr[`SC_REG_ADDR_W-1:0];
    @(posedge stream_in);
    reg_req <= req;
    exp_due.push_back(cyc + 2);
    exp_data.push_back(expected);
    exp_name.push_back(name);
  endtask

  task automatic drive_samples(input int unsigned count, input string name);
    lane_samples_t   s;
    logic [SW-1:0]   word;
    for (int unsigned i = 0; i < count; i++) begin
      for (int l = 0; l < LANES; l++) begin
        next_sample(word);
        s[l] = word;
      end
      @(posedge stream_in);
      reg_req      <= '0;
      sample_valid <= 1'b1;
      sample_data  <= s;
      model_sample(s);
    end
    @(posedge stream_in);
    sample_valid <= 1'b0;
    @(negedge stream_in);
    check_value({name, "_busy"}, 32'(m_en), 32'(lane_busy));
  endtask

  task automatic pulse_trigger();
    @(posedge stream_in);
    reg_req <= '0;
    trigger <= 1'b1;
    @(posedge stream_in);
    trigger <= 1'b0;
    if (m_armed) begin
      m_armed = 1'b0;
      model_start();
    end
  endtask

  task automatic wait_idle();
    @(posedge stream_in);
    reg_req <= '0;
    @(negedge stream_in);
    while (lane_busy != '0 || exp_due.size() != 0) @(negedge stream_in);
  endtask

  // ***********************************************************
  // Response monitor and watchdog
  // ***********************************************************

  always @(negedge stream_in) begin
    if (reg_rsp.valid) begin
      if (exp_due.size() == 0) begin
        check_value("unexpected_response", 32'd0, 32'(reg_rsp.valid));
      end else begin
        check_value({exp_name[0], "_latency"}, exp_due[0], cyc);
        check_value(exp_name[0], exp_data[0], reg_rsp.rdata);
        void'(exp_due.pop_front());
        void'(exp_data.pop_front());
        void'(exp_name.pop_front());
      end
    end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
      check_value({exp_name[0], "_response"}, 32'd1, 32'(reg_rsp.valid));
    end
    cyc++;
  end

  initial begin
    wait (budget_cycles != 0);
    #(budget_cycles * 4);
    $display("Watchdog timeout after %0d cycles, the run did not complete.", budget_cycles);
    $display("Simulation FAILED");
    $fatal(1, "Timeout.");
  end

  // ***********************************************************
  // Main sequence
  // ***********************************************************

  initial begin
    arst_n       = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    trigger      = 1'b0;
    reg_req      = '0;
    lfsr         = 32'd88938;
    model_reset();
    load_patterns();
    repeat (4) @(posedge stream_in);
    arst_n <= 1'b1;
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "W": reg_write(addr_q[i], data_q[i]);
        "R": reg_read(addr_q[i], data_q[i], name_q[i]);
        "S": drive_samples(data_q[i], name_q[i]);
        "T": pulse_trigger();
        "I": wait_idle();
        default: begin
          $display("Unknown command in pattern row %s.", name_q[i]);
          $display("Simulation FAILED");
          $fatal(1, "Bad pattern file.");
        end
      endcase
    end
    @(posedge stream_in);
    reg_req <= '0;
    while (exp_due.size() != 0) @(negedge stream_in);
    repeat (2) @(posedge stream_in);
    if (error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "Checks failed.");
    end
  end

endmodule

// ==== sample_capture_patterns.txt ====
# cmd addr data name, cmd is W write, R read-expect, S samples, T trigger, I wait-idle
# addr and data in hex; buffer reads take their expected value from the lane model
R 003 00000000 status_after_reset
W 001 00000000 fill_start_wr
W 002 0000003f fill_end_wr
W 000 00000003 fill_go
S 000 00000040 fill_samples
I 000 00000000 fill_idle
W 001 0000000a region_start_wr
W 002 00000014 region_end_wr
W 004 0000000f lane_en_all_wr
R 001 0000000a start_readback
R 002 00000014 end_readback
R 004 0000000f lane_en_readback
R 007 00000000 unmapped_readback
W 000 00000003 oneshot_go
S 000 00000018 oneshot_samples
I 000 00000000 oneshot_idle
R 109 00000000 oneshot_below_l0
R 10a 00000000 oneshot_first_l0
R 114 00000000 oneshot_last_l0
R 115 00000000 oneshot_above_l0
R 1ca 00000000 oneshot_first_l3
R 003 00000000 oneshot_status
W 001 00000004 cont_start_wr
W 002 00000007 cont_end_wr
W 000 00000001 cont_go
S 000 0000000a cont_samples
W 000 00000008 cont_stop
I 000 00000000 cont_idle
R 143 00000000 cont_below_l1
R 144 00000000 cont_off4_l1
R 145 00000000 cont_off5_l1
R 147 00000000 cont_off7_l1
R 148 00000000 cont_above_l1
W 001 00000020 trig_start_wr
W 002 00000027 trig_end_wr
W 004 0000000b mask_wr
W 000 00000007 trig_arm
R 003 00000100 status_armed
S 000 00000005 pre_trigger_samples
T 000 00000000 trigger_pulse
R 003 0000000b status_capturing
S 000 00000008 trig_samples
I 000 00000000 trig_idle
R 11f 00000000 trig_below_l0
R 120 00000000 trig_first_l0
R 003 00000000 status_done
R 1a0 00000000 masked_first_l2
R 1e7 00000000 trig_last_l3
R 1a7 00000000 masked_last_l2
R 004 0000000b mask_readback
R 167 00000000 trig_last_l1

// ==== sample_capture_top.f ====
+incdir+.
sample_capture_pkg.sv
capture_csr.sv
capture_lane.sv
capture_readback.sv
sample_capture_top.sv
tb_sample_capture.sv
